// ==== hw/vlat_bank.sv ====
// ****************************************
// Memory bank
// 64 words, byte-enable writes, response
// after a pseudo-random 1 to 3 cycles
// ****************************************

`timescale 1ns/1ps

module vlat_bank import vlat_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_vld_i,
  input  bank_req_t  req_i,
  output logic       rdy_o,       // High while idle
  output logic       resp_vld_o,  // One-cycle pulse at end of latency
  output bank_resp_t resp_o
);

  data_t       mem_q [2**MEM_ADDR_W];
  bank_state_e state_q;
  logic [7:0]  lfsr_q;     // Latency source
  logic [1:0]  lat_cnt_q;  // Remaining busy cycles
  logic        accept;
  data_t       old_word;
  data_t       new_word;
  bank_resp_t  resp_q;

  assign rdy_o    = (state_q == BANK_IDLE);
  assign accept   = req_vld_i && rdy_o;
  assign old_word = mem_q[req_i.addr];

  // Byte merge of write data into the stored word
  always_comb begin
    new_word = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (req_i.be[b]) new_word[8*b +: 8] = req_i.wdata[8*b +: 8];
    end
  end

  // Access happens at acceptance, result parked in resp_q
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.wen) mem_q[req_i.addr] <= new_word;
      resp_q.ini   <= req_i.ini;
      resp_q.rdata <= req_i.wen ? new_word : old_word;  // Old word on reads
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= BANK_IDLE;
      lat_cnt_q <= '0;
      lfsr_q    <= 8'hA5;  // Any nonzero seed
    end else begin
      case (state_q)
        BANK_IDLE: begin
          if (accept) begin
            state_q   <= BANK_BUSY;
            lat_cnt_q <= 2'(lfsr_q % MAX_LAT) + 2'd1;  // 1 to MAX_LAT
            // Taps 8,6,5,4
            lfsr_q    <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
          end
        end
        BANK_BUSY: begin
          lat_cnt_q <= lat_cnt_q - 2'd1;
          if (lat_cnt_q == 2'd1) state_q <= BANK_IDLE;  // Last busy cycle
        end
        default: state_q <= BANK_IDLE;
      endcase
    end
  end

  assign resp_vld_o = (state_q == BANK_BUSY) && (lat_cnt_q == 2'd1);
  assign resp_o     = resp_q;

endmodule

// ==== hw/vlat_pkg.sv ====
// ****************************************
// Variable-latency interconnect package
// Shared counts, widths, vector types and
// the bank request and response structs
// ****************************************

package vlat_pkg;

  // Topology
  localparam int unsigned NUM_INI         = 4;  // Initiators
  localparam int unsigned NUM_BANKS       = 4;  // Word-interleaved banks

  // Data path
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned BE_W            = DATA_W / 8;

  // Address layout, LSB first: byte offset, bank select, word address
  localparam int unsigned ADDR_W          = 12;
  localparam int unsigned BYTE_OFF_W      = 2;
  localparam int unsigned BANK_W          = 2;  // log2 of NUM_BANKS
  localparam int unsigned MEM_ADDR_W      = 6;  // 64 words per bank
  localparam int unsigned INI_W           = 2;  // log2 of NUM_INI

  // Response queue sizing
  localparam int unsigned NUM_OUTSTANDING = 2;  // Per bank
  localparam int unsigned CNT_W           = 2;  // Holds 0 to NUM_OUTSTANDING
  localparam int unsigned MAX_LAT         = 3;  // Longest bank latency in cycles

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [BANK_W-1:0]     bank_idx_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [INI_W-1:0]      ini_idx_t;

  // Request as seen by one bank, 45 bits
  typedef struct packed {
    ini_idx_t  ini;    // Who asked, travels back with the response
    logic      wen;    // 1 = write
    be_t       be;
    mem_addr_t addr;   // Word inside the bank
    data_t     wdata;
  } bank_req_t;

  // Response from one bank, 34 bits
  typedef struct packed {
    ini_idx_t ini;     // Destination initiator
    data_t    rdata;   // Old word on reads, merged word on writes
  } bank_resp_t;

  // Bank access FSM
  typedef enum logic {
    BANK_IDLE,
    BANK_BUSY
  } bank_state_e;

endpackage

// ==== hw/vlat_req_xbar.sv ====
// ****************************************
// Request crossbar
// Decodes the bank from each address and
// runs one round-robin arbiter per bank
// ****************************************

`timescale 1ns/1ps

module vlat_req_xbar import vlat_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Initiator side
  input  logic      [NUM_INI-1:0]      req_i,
  input  addr_t     [NUM_INI-1:0]      add_i,
  input  logic      [NUM_INI-1:0]      wen_i,
  input  data_t     [NUM_INI-1:0]      wdata_i,
  input  be_t       [NUM_INI-1:0]      be_i,
  output logic      [NUM_INI-1:0]      gnt_o,
  // Bank side
  input  logic      [NUM_BANKS-1:0]    credit_ok_i,  // Queue has room
  input  logic      [NUM_BANKS-1:0]    bank_rdy_i,   // Bank idle
  output bank_req_t [NUM_BANKS-1:0]    bank_req_o,
  output logic      [NUM_BANKS-1:0]    bank_vld_o
);

  bank_idx_t [NUM_INI-1:0]            bank_sel;  // Target bank per initiator
  logic      [NUM_BANKS-1:0][NUM_INI-1:0] hit;   // Requests per bank
  logic      [NUM_BANKS-1:0]          any_hit;
  ini_idx_t  [NUM_BANKS-1:0]          win;       // Arbitration winner
  ini_idx_t  [NUM_BANKS-1:0]          rr_q;      // Highest priority initiator

  // Bank select sits right above the byte offset
  always_comb begin
    for (int i = 0; i < NUM_INI; i++) begin
      bank_sel[i] = add_i[i][BYTE_OFF_W +: BANK_W];
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int i = 0; i < NUM_INI; i++) begin
        hit[b][i] = req_i[i] && (bank_sel[i] == bank_idx_t'(b));
      end
    end
  end

  // Round-robin search starting at the pointer, wraps modulo NUM_INI
  always_comb begin
    ini_idx_t idx;
    win     = rr_q;
    any_hit = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int k = 0; k < NUM_INI; k++) begin
        idx = rr_q[b] + ini_idx_t'(k);
        if (!any_hit[b] && hit[b][idx]) begin
          any_hit[b] = 1'b1;
          win[b]     = idx;
        end
      end
    end
  end

  assign bank_vld_o = any_hit & credit_ok_i;  // No strobe without a credit

  // Pack the winner's fields for each bank
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req_o[b].ini   = win[b];
      bank_req_o[b].wen   = wen_i[win[b]];
      bank_req_o[b].be    = be_i[win[b]];
      bank_req_o[b].addr  = add_i[win[b]][BYTE_OFF_W + BANK_W +: MEM_ADDR_W];
      bank_req_o[b].wdata = wdata_i[win[b]];
    end
  end

  // Grant back to the winner only when the bank takes it this cycle
  always_comb begin
    for (int i = 0; i < NUM_INI; i++) begin
      gnt_o[i] = req_i[i] && bank_vld_o[bank_sel[i]] && bank_rdy_i[bank_sel[i]]
                 && (win[bank_sel[i]] == ini_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (bank_vld_o[b] && bank_rdy_i[b]) rr_q[b] <= win[b] + 1'b1;  // Skip past winner
      end
    end
  end

endmodule

// ==== hw/vlat_resp_queue.sv ====
// ****************************************
// Bank response queue
// Two-entry FIFO plus a credit counter
// that reserves a slot at grant time
// ****************************************

`timescale 1ns/1ps

module vlat_resp_queue import vlat_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       grant_i,      // Request accepted by the bank
  input  logic       push_i,       // Bank response valid
  input  bank_resp_t data_i,
  input  logic       pop_i,        // Head taken by the response crossbar
  output logic       credit_ok_o,  // Room for one more transaction
  output logic       not_empty_o,
  output bank_resp_t data_o        // Head entry
);

  bank_resp_t       fifo_q [NUM_OUTSTANDING];  // Payload only
  logic [CNT_W-1:0] wr_ptr_q;  // MSB is the wrap bit
  logic [CNT_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] credit_q;  // Granted but not yet popped
  logic [CNT_W-1:0] credit_d;

  always_ff @(posedge clk_i) begin
    if (push_i) fifo_q[wr_ptr_q[CNT_W-2:0]] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;  // Never full, credit guarantees it
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign not_empty_o = (wr_ptr_q != rd_ptr_q);
  assign data_o      = fifo_q[rd_ptr_q[CNT_W-2:0]];

  // Outstanding count, up on grant, down on pop
  always_comb begin
    credit_d = credit_q;
    case ({grant_i, pop_i})
      2'b10:   credit_d = credit_q + 1'b1;
      2'b01:   credit_d = credit_q - 1'b1;
      default: credit_d = credit_q;  // Both or neither
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  // Block new grants once every slot is spoken for
  assign credit_ok_o = (credit_q != CNT_W'(NUM_OUTSTANDING));

endmodule

// ==== hw/vlat_resp_xbar.sv ====
// ****************************************
// Response crossbar
// Routes queue heads to initiators with a
// round-robin pick and rdy back-pressure
// ****************************************

`timescale 1ns/1ps

module vlat_resp_xbar import vlat_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Queue side
  input  logic       [NUM_BANKS-1:0]    head_vld_i,
  input  bank_resp_t [NUM_BANKS-1:0]    head_i,
  output logic       [NUM_BANKS-1:0]    pop_o,
  // Initiator side
  output logic       [NUM_INI-1:0]      vld_o,
  output data_t      [NUM_INI-1:0]      rdata_o,
  input  logic       [NUM_INI-1:0]      rdy_i
);

  logic      [NUM_INI-1:0][NUM_BANKS-1:0] match;  // Heads bound for each initiator
  bank_idx_t [NUM_INI-1:0]  sel;         // Bank chosen per initiator
  bank_idx_t [NUM_INI-1:0]  rr_q;        // Round-robin pointer over banks
  logic      [NUM_INI-1:0]  lock_q;      // Offered response waiting on rdy
  bank_idx_t [NUM_INI-1:0]  lock_sel_q;

  always_comb begin
    for (int i = 0; i < NUM_INI; i++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        match[i][b] = head_vld_i[b] && (head_i[b].ini == ini_idx_t'(i));
      end
    end
  end

  // Pick a bank per initiator, keep the offered one while stalled
  always_comb begin
    bank_idx_t idx;
    sel   = rr_q;
    vld_o = '0;
    for (int i = 0; i < NUM_INI; i++) begin
      for (int k = 0; k < NUM_BANKS; k++) begin
        idx = rr_q[i] + bank_idx_t'(k);
        if (!vld_o[i] && match[i][idx]) begin
          vld_o[i] = 1'b1;
          sel[i]   = idx;
        end
      end
      if (lock_q[i]) sel[i] = lock_sel_q[i];  // Head stays put until popped
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_INI; i++) begin
      rdata_o[i] = head_i[sel[i]].rdata;
    end
  end

  // Each head has one destination, so at most one initiator pops a bank
  always_comb begin
    pop_o = '0;
    for (int i = 0; i < NUM_INI; i++) begin
      if (vld_o[i] && rdy_i[i]) pop_o[sel[i]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= '0;
      lock_sel_q <= '0;
    end else begin
      for (int i = 0; i < NUM_INI; i++) begin
        lock_q[i] <= vld_o[i] && !rdy_i[i];
        if (vld_o[i]) lock_sel_q[i] <= sel[i];
        if (vld_o[i] && rdy_i[i]) rr_q[i] <= sel[i] + 1'b1;  // Handshake done
      end
    end
  end

endmodule

// ==== hw/vlat_top.sv ====
// ****************************************
// Variable-latency interconnect top
// Four initiators, four banks, crossbars
// and per-bank response queues
// ****************************************

`timescale 1ns/1ps

module vlat_top import vlat_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Initiator requests
  input  logic  [NUM_INI-1:0]     req_i,
  output logic  [NUM_INI-1:0]     gnt_o,
  input  addr_t [NUM_INI-1:0]     add_i,
  input  logic  [NUM_INI-1:0]     wen_i,
  input  data_t [NUM_INI-1:0]     wdata_i,
  input  be_t   [NUM_INI-1:0]     be_i,
  // Initiator responses
  output logic  [NUM_INI-1:0]     vld_o,
  input  logic  [NUM_INI-1:0]     rdy_i,
  output data_t [NUM_INI-1:0]     rdata_o
);

  bank_req_t  [NUM_BANKS-1:0] bank_req;
  logic       [NUM_BANKS-1:0] bank_vld;
  logic       [NUM_BANKS-1:0] bank_rdy;
  logic       [NUM_BANKS-1:0] credit_ok;
  logic       [NUM_BANKS-1:0] resp_vld;   // Bank to queue
  bank_resp_t [NUM_BANKS-1:0] resp;
  logic       [NUM_BANKS-1:0] head_vld;   // Queue to response crossbar
  bank_resp_t [NUM_BANKS-1:0] head;
  logic       [NUM_BANKS-1:0] head_pop;

  vlat_req_xbar i_req_xbar (
    .clk_i       (clk_i    ),
    .rst_ni      (rst_ni   ),
    .req_i       (req_i    ),
    .add_i       (add_i    ),
    .wen_i       (wen_i    ),
    .wdata_i     (wdata_i  ),
    .be_i        (be_i     ),
    .gnt_o       (gnt_o    ),
    .credit_ok_i (credit_ok),
    .bank_rdy_i  (bank_rdy ),
    .bank_req_o  (bank_req ),
    .bank_vld_o  (bank_vld )
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks
    vlat_bank i_bank (
      .clk_i      (clk_i      ),
      .rst_ni     (rst_ni     ),
      .req_vld_i  (bank_vld[b]),
      .req_i      (bank_req[b]),
      .rdy_o      (bank_rdy[b]),
      .resp_vld_o (resp_vld[b]),
      .resp_o     (resp[b]    )
    );

    vlat_resp_queue i_resp_queue (
      .clk_i       (clk_i                    ),
      .rst_ni      (rst_ni                   ),
      .grant_i     (bank_vld[b] & bank_rdy[b]),  // Accepted this cycle
      .push_i      (resp_vld[b]              ),
      .data_i      (resp[b]                  ),
      .pop_i       (head_pop[b]              ),
      .credit_ok_o (credit_ok[b]             ),
      .not_empty_o (head_vld[b]              ),
      .data_o      (head[b]                  )
    );
  end

  vlat_resp_xbar i_resp_xbar (
    .clk_i      (clk_i   ),
    .rst_ni     (rst_ni  ),
    .head_vld_i (head_vld),
    .head_i     (head    ),
    .pop_o      (head_pop),
    .vld_o      (vld_o   ),
    .rdata_o    (rdata_o ),
    .rdy_i      (rdy_i   )
  );

endmodule

// ==== tests/vlat_cases.txt ====
# step ini op(1=write) addr data be bp(0=ready 1=random 2=low for 16 cycles), hex for addr data be
# Lines with the same step are issued in parallel, one per initiator
1 0 1 010 11223344 f 0
2 0 1 010 aabbccdd 5 0
3 0 0 010 00000000 0 0
4 0 1 020 a0a0a0a0 f 0
4 1 1 024 b1b1b1b1 f 0
4 2 1 028 c2c2c2c2 f 0
4 3 1 02c d3d3d3d3 f 0
5 0 0 02c 00000000 0 0
5 1 0 028 00000000 0 0
5 2 0 024 00000000 0 0
5 3 0 020 00000000 0 0
6 1 1 030 12345678 f 1
6 2 1 030 9abcdef0 3 1
7 3 0 030 00000000 0 0
8 2 0 024 00000000 0 2
9 0 0 010 00000000 0 2
9 1 0 020 00000000 0 2
9 2 0 030 00000000 0 2
10 0 1 140 cafef00d f 1
10 3 1 154 0badbeef 6 1
11 1 0 154 00000000 0 1
11 2 0 140 00000000 0 1

// ==== tests/vlat_checker.sv ====
// ****************************************
// Interconnect checker
// Reference memory, response prediction,
// stall stability and per-bank credit count
// ****************************************

`timescale 1ns/1ps

module vlat_checker import vlat_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic  [NUM_INI-1:0]  req_i,
  input  logic  [NUM_INI-1:0]  gnt_i,
  input  addr_t [NUM_INI-1:0]  add_i,
  input  logic  [NUM_INI-1:0]  wen_i,
  input  data_t [NUM_INI-1:0]  wdata_i,
  input  be_t   [NUM_INI-1:0]  be_i,
  input  logic  [NUM_INI-1:0]  vld_i,
  input  logic  [NUM_INI-1:0]  rdy_i,
  input  data_t [NUM_INI-1:0]  rdata_i,
  output int                   err_cnt_o,
  output int                   resp_cnt_o
);

  data_t     ref_mem [2**(BANK_W+MEM_ADDR_W)];  // Bank bits are the low index bits
  data_t     exp_q   [NUM_INI];   // Predicted response
  logic      pend_q  [NUM_INI];
  bank_idx_t bank_q  [NUM_INI];   // Bank of the pending request
  int        out_cnt [NUM_BANKS]; // Accepted requests minus accepted responses
  logic      held_q  [NUM_INI];   // Offered last cycle without rdy
  data_t     held_data_q [NUM_INI];
  int        err_cnt  = 0;
  int        resp_cnt = 0;

  assign err_cnt_o  = err_cnt;
  assign resp_cnt_o = resp_cnt;

  always @(posedge clk_i) begin
    data_t     word;
    int        a;
    bank_idx_t b;
    if (!rst_ni) begin
      for (int i = 0; i < NUM_INI; i++) begin
        pend_q[i] = 1'b0;
        held_q[i] = 1'b0;
      end
      for (int k = 0; k < NUM_BANKS; k++) out_cnt[k] = 0;
    end else begin
      // Responses first
      for (int i = 0; i < NUM_INI; i++) begin
        if (held_q[i] && !vld_i[i]) begin
          $display("mismatch at %0t: vld_o[%0d] got 0 expected 1", $time, i);
          err_cnt++;
        end else if (held_q[i] && rdata_i[i] !== held_data_q[i]) begin
          $display("mismatch at %0t: rdata_o[%0d] got %h expected %h (stalled)",
                   $time, i, rdata_i[i], held_data_q[i]);
          err_cnt++;
        end
        held_q[i]      = vld_i[i] && !rdy_i[i];
        held_data_q[i] = rdata_i[i];
        if (vld_i[i] && rdy_i[i]) begin
          resp_cnt++;
          if (!pend_q[i]) begin
            $display("initiator %0d got a response it never asked for", i);
            err_cnt++;
          end else if (rdata_i[i] !== exp_q[i]) begin
            $display("mismatch at %0t: rdata_o[%0d] got %h expected %h",
                     $time, i, rdata_i[i], exp_q[i]);
            err_cnt++;
          end else begin
            $display("case done: initiator %0d rdata %h ok", i, rdata_i[i]);
          end
          if (pend_q[i]) out_cnt[bank_q[i]]--;  // Frees a slot
          pend_q[i] = 1'b0;
        end
      end
      // Accepted requests update the reference memory in grant order
      for (int i = 0; i < NUM_INI; i++) begin
        if (req_i[i] && gnt_i[i]) begin
          a    = add_i[i][BYTE_OFF_W +: BANK_W+MEM_ADDR_W];
          b    = add_i[i][BYTE_OFF_W +: BANK_W];
          word = ref_mem[a];
          if (wen_i[i]) begin
            for (int k = 0; k < BE_W; k++) begin
              if (be_i[i][k]) word[8*k +: 8] = wdata_i[i][8*k +: 8];  // Byte merge
            end
            ref_mem[a] = word;
          end
          exp_q[i]  = word;
          pend_q[i] = 1'b1;
          bank_q[i] = b;
          out_cnt[b]++;
          if (out_cnt[b] > NUM_OUTSTANDING) begin
            $display("bank %0d holds %0d outstanding transactions, limit is %0d",
                     b, out_cnt[b], NUM_OUTSTANDING);
            err_cnt++;
          end
        end
      end
    end
  end

endmodule

// ==== tests/vlat_tb.sv ====
// ****************************************
// Interconnect testbench
// Reads the cases file, drives the four
// initiators and the response back-pressure
// ****************************************

`timescale 1ns/1ps

module vlat_tb import vlat_pkg::*; ();

  localparam int MAX_CASES = 64;
  localparam int TIMEOUT   = 200;  // Cycles per wait

  // One line of the cases file
  typedef struct packed {
    int         step;  // Same step runs in parallel
    ini_idx_t   ini;
    logic       wen;
    addr_t      addr;
    data_t      data;
    be_t        be;
    logic [1:0] bp;    // 0 ready, 1 random, 2 held low
  } case_t;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic  [NUM_INI-1:0] req_i;
  logic  [NUM_INI-1:0] gnt_o;
  addr_t [NUM_INI-1:0] add_i;
  logic  [NUM_INI-1:0] wen_i;
  data_t [NUM_INI-1:0] wdata_i;
  be_t   [NUM_INI-1:0] be_i;
  logic  [NUM_INI-1:0] vld_o;
  logic  [NUM_INI-1:0] rdy_i;
  data_t [NUM_INI-1:0] rdata_o;
  case_t               cases [MAX_CASES];
  int                  n_cases;
  int                  slot [NUM_INI];  // Case index per initiator or -1 when idle
  int                  seed = 4;
  logic                stalled;
  int                  err_cnt;
  int                  resp_cnt;

  always #4 clk_i = ~clk_i;

  vlat_top dut_i (.*);

  vlat_checker chk_i (
    .clk_i      (clk_i   ),
    .rst_ni     (rst_ni  ),
    .req_i      (req_i   ),
    .gnt_i      (gnt_o   ),
    .add_i      (add_i   ),
    .wen_i      (wen_i   ),
    .wdata_i    (wdata_i ),
    .be_i       (be_i    ),
    .vld_i      (vld_o   ),
    .rdy_i      (rdy_i   ),
    .rdata_i    (rdata_o ),
    .err_cnt_o  (err_cnt ),
    .resp_cnt_o (resp_cnt)
  );

  task automatic read_cases();
    int          fd;
    int          s, i, o, bp;
    logic [31:0] a, d, b;
    string       line;
    n_cases = 0;
    fd = $fopen("tests/vlat_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the cases file");
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
      if ($sscanf(line, "%d %d %d %h %h %h %d", s, i, o, a, d, b, bp) != 7) continue;
      cases[n_cases].step = s;
      cases[n_cases].ini  = ini_idx_t'(i);
      cases[n_cases].wen  = o[0];
      cases[n_cases].addr = addr_t'(a);
      cases[n_cases].data = d;
      cases[n_cases].be   = be_t'(b);
      cases[n_cases].bp   = bp[1:0];
      n_cases++;
    end
    $fclose(fd);
  endtask

  // Next rdy level for a waiting initiator where t counts cycles since the grant
  function automatic logic rdy_for_cycle(input logic [1:0] bp, input int t);
    case (bp)
      2'd0:    return 1'b1;
      2'd1:    return ($random(seed) & 1) != 0;
      default: return t >= 16;
    endcase
  endfunction

  // Issue one request, wait for its grant and then for its response
  task automatic serve_initiator(input int ini);
    case_t c;
    int    t;
    logic  got;
    if (slot[ini] < 0) return;
    c            = cases[slot[ini]];
    req_i[ini]   <= 1'b1;
    add_i[ini]   <= c.addr;
    wen_i[ini]   <= c.wen;
    wdata_i[ini] <= c.data;
    be_i[ini]    <= c.be;
    t   = 0;
    got = 1'b0;
    while (!got && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
      got = gnt_o[ini];
    end
    req_i[ini] <= 1'b0;
    if (!got) begin
      $display("initiator %0d got no grant within %0d cycles", ini, TIMEOUT);
      stalled = 1'b1;
      return;
    end
    t = 0;
    got = 1'b0;
    rdy_i[ini] <= rdy_for_cycle(c.bp, t);
    while (!got && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
      got = vld_o[ini] && rdy_i[ini];  // Handshake seen on this edge
      rdy_i[ini] <= got ? 1'b1 : rdy_for_cycle(c.bp, t);
    end
    if (!got) begin
      $display("initiator %0d got no response within %0d cycles", ini, TIMEOUT);
      stalled = 1'b1;
    end
  endtask

  initial begin
    int first;
    int last;
    rst_ni  = 1'b0;
    req_i   = '0;
    add_i   = '0;
    wen_i   = '0;
    wdata_i = '0;
    be_i    = '0;
    rdy_i   = '1;
    stalled = 1'b0;
    read_cases();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    first = 0;
    while (first < n_cases) begin
      last = first;
      for (int i = 0; i < NUM_INI; i++) begin
        slot[i] = -1;
      end
      while (last < n_cases && cases[last].step == cases[first].step) begin
        slot[cases[last].ini] = last;
        last++;
      end
      fork
        serve_initiator(0);
        serve_initiator(1);
        serve_initiator(2);
        serve_initiator(3);
      join
      @(posedge clk_i);
      first = last;
    end
    repeat (4) @(posedge clk_i);
    $display("cases %0d, responses %0d, errors %0d, stalled %0d",
             n_cases, resp_cnt, err_cnt, stalled);
    if (n_cases > 0 && err_cnt == 0 && resp_cnt == n_cases && !stalled) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== vlat_interconnect.f ====
hw/vlat_pkg.sv
hw/vlat_req_xbar.sv
hw/vlat_bank.sv
hw/vlat_resp_queue.sv
hw/vlat_resp_xbar.sv
hw/vlat_top.sv
tests/vlat_checker.sv
tests/vlat_tb.sv
